// File: hw/sya_settings.svh
/*
 * Systolic engine build settings
 * Grid dimension, operand and accumulator widths,
 * buffer address and counter widths, flush length
 */
`ifndef SYA_SETTINGS_SVH
`define SYA_SETTINGS_SVH

// Grid is SYA_DIM x SYA_DIM processing elements
`define SYA_DIM        4

// Operand widths
`define SYA_ACT_W      8
`define SYA_WGT_W      8

// Product width plus 8 bits of channel growth
`define SYA_PSUM_W     24

// Global buffer address and loop counters
`define SYA_ADDR_W     16
`define SYA_CNT_W      8

// Cycles after the last read until every cell has its last product
`define SYA_FLUSH_CYC  (3 * `SYA_DIM)

`endif

// File: hw/sya_pkg.sv
/*
 * Systolic engine shared types
 * Scalar and vector data types, configuration word,
 * output write bundle and run state encoding
 */
`include "sya_settings.svh"

package sya_pkg;

    // Scalar types
    typedef logic signed [`SYA_ACT_W-1:0]  act_t;
    typedef logic signed [`SYA_WGT_W-1:0]  wgt_t;
    typedef logic signed [`SYA_PSUM_W-1:0] psum_t;
    typedef logic [`SYA_ADDR_W-1:0]        addr_t;
    typedef logic [`SYA_CNT_W-1:0]         cnt_t;

    // One operand per grid row / column
    typedef act_t [`SYA_DIM-1:0] act_vec_t;
    typedef wgt_t [`SYA_DIM-1:0] wgt_vec_t;

    // Accumulators indexed [row][col]
    typedef psum_t [`SYA_DIM-1:0][`SYA_DIM-1:0] psum_mat_t;

    // Configuration word, MSB first
    typedef struct packed {
        addr_t      act_base;
        addr_t      wgt_base;
        addr_t      ofm_base;
        cnt_t       chn;
        cnt_t       num_grp;
        logic [3:0] shift;
        act_t       zp;
    } sya_cfg_t;

    // One requantized output row
    typedef struct packed {
        addr_t    addr;
        act_vec_t data;
    } ofm_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        FEED,
        FLUSH,
        DRAIN
    } sya_state_e;

endpackage

// File: hw/sya_ctrl.sv
/*
 * Systolic engine control
 * Configuration latch and run FSM
 * Channel, phase and group counters
 * Accumulator clear and drain row strobes
 */
`include "sya_settings.svh"

module sya_ctrl
    import sya_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_vld,
    input  sya_cfg_t                    cfg,
    output logic                        cfg_rdy,
    output sya_cfg_t                    cfg_q,
    output sya_state_e                  state,
    output cnt_t                        k,
    output cnt_t                        g,
    output logic                        acc_clr,
    output logic                        drain_row_vld,
    output logic [$clog2(`SYA_DIM)-1:0] drain_row
);
    localparam int PH_W = $clog2(`SYA_FLUSH_CYC);

    sya_state_e      next_state;
    logic [PH_W-1:0] ph_cnt;
    logic            k_last;
    logic            flush_last;
    logic            row_last;
    logic            grp_last;

    assign cfg_rdy       = (state == IDLE);
    assign k_last        = (k == cfg_q.chn - cnt_t'(1));
    assign flush_last    = (ph_cnt == PH_W'(`SYA_FLUSH_CYC - 1));
    assign row_last      = (ph_cnt == PH_W'(`SYA_DIM - 1));
    assign grp_last      = (g == cfg_q.num_grp - cnt_t'(1));
    assign drain_row_vld = (state == DRAIN);
    assign drain_row     = ph_cnt[$clog2(`SYA_DIM)-1:0];

    // ============================================================
    // Run FSM
    // ============================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cfg_vld) begin
                    next_state = FEED;
                end
            end
            FEED: begin
                if (k_last) begin
                    next_state = FLUSH;
                end
            end
            FLUSH: begin
                if (flush_last) begin
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                if (row_last) begin
                    next_state = grp_last ? IDLE : FEED;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // ============================================================
    // Registers and counters
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cfg_q   <= '0;
            k       <= '0;
            g       <= '0;
            ph_cnt  <= '0;
            acc_clr <= 1'b0;
        end else begin
            state <= next_state;
            // One-cycle clear on every entry to FEED
            acc_clr <= (next_state == FEED) && (state != FEED);
            if (cfg_rdy && cfg_vld) begin
                cfg_q <= cfg;
            end
            k <= (state == FEED && !k_last) ? k + cnt_t'(1) : '0;
            // Shared by FLUSH length and DRAIN row index
            if ((state == FLUSH && !flush_last) || (state == DRAIN && !row_last)) begin
                ph_cnt <= ph_cnt + PH_W'(1);
            end else begin
                ph_cnt <= '0;
            end
            if (state == IDLE) begin
                g <= '0;
            end else if (state == DRAIN && row_last) begin
                g <= g + cnt_t'(1);
            end
        end
    end

endmodule

// File: hw/sya_addr_gen.sv
/*
 * Global buffer read address generation
 * Activation address with group offset, shared weight address,
 * registered read strobe
 */
module sya_addr_gen
    import sya_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  sya_state_e state,
    input  sya_cfg_t   cfg_q,
    input  cnt_t       k,
    input  cnt_t       g,
    output logic       rd_req,
    output addr_t      act_rd_addr,
    output addr_t      wgt_rd_addr
);
    addr_t grp_off;
    addr_t k_off;

    // Each group reads its own chn activation vectors
    assign grp_off = addr_t'(g) * addr_t'(cfg_q.chn);
    assign k_off   = addr_t'(k);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req      <= 1'b0;
            act_rd_addr <= '0;
            wgt_rd_addr <= '0;
        end else if (state == FEED) begin
            rd_req      <= 1'b1;
            act_rd_addr <= cfg_q.act_base + grp_off + k_off;
            // Weights are reused by every group
            wgt_rd_addr <= cfg_q.wgt_base + k_off;
        end else begin
            rd_req      <= 1'b0;
            act_rd_addr <= '0;
            wgt_rd_addr <= '0;
        end
    end

endmodule

// File: hw/sya_skew.sv
/*
 * Operand skew on entry to the grid
 * Activation row r and weight column c delayed by r and c cycles,
 * valid bits carried alongside
 */
`include "sya_settings.svh"

module sya_skew
    import sya_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  act_vec_t            rd_act,
    input  wgt_vec_t            rd_wgt,
    input  logic                rd_vld,
    output act_vec_t            act_in,
    output logic [`SYA_DIM-1:0] act_in_vld,
    output wgt_vec_t            wgt_in,
    output logic [`SYA_DIM-1:0] wgt_in_vld
);

    for (genvar i = 0; i < `SYA_DIM; i++) begin : g_lane
        if (i == 0) begin : g_pass
            // Lane 0 enters the grid undelayed
            assign act_in[i]     = rd_act[i];
            assign wgt_in[i]     = rd_wgt[i];
            assign act_in_vld[i] = rd_vld;
            assign wgt_in_vld[i] = rd_vld;
        end else begin : g_dly
            act_t act_sr [i];
            wgt_t wgt_sr [i];
            logic vld_sr [i];

            always_ff @(posedge clk) begin
                act_sr[0] <= rd_act[i];
                wgt_sr[0] <= rd_wgt[i];
                for (int j = 1; j < i; j++) begin
                    act_sr[j] <= act_sr[j-1];
                    wgt_sr[j] <= wgt_sr[j-1];
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int j = 0; j < i; j++) begin
                        vld_sr[j] <= 1'b0;
                    end
                end else begin
                    vld_sr[0] <= rd_vld;
                    for (int j = 1; j < i; j++) begin
                        vld_sr[j] <= vld_sr[j-1];
                    end
                end
            end

            assign act_in[i]     = act_sr[i-1];
            assign wgt_in[i]     = wgt_sr[i-1];
            assign act_in_vld[i] = vld_sr[i-1];
            assign wgt_in_vld[i] = vld_sr[i-1];
        end
    end

endmodule

// File: hw/sya_pe.sv
/*
 * Processing element
 * Signed multiply-accumulate, activation forwarded east,
 * weight forwarded south
 */
`include "sya_settings.svh"

module sya_pe
    import sya_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clr,
    input  act_t  act_i,
    input  logic  act_vld_i,
    input  wgt_t  wgt_i,
    input  logic  wgt_vld_i,
    output act_t  act_o,
    output logic  act_vld_o,
    output wgt_t  wgt_o,
    output logic  wgt_vld_o,
    output psum_t psum
);
    logic signed [`SYA_ACT_W+`SYA_WGT_W-1:0] prod;

    assign prod = act_i * wgt_i;

    // Operand forwarding, one hop per cycle
    always_ff @(posedge clk) begin
        act_o <= act_i;
        wgt_o <= wgt_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_vld_o <= 1'b0;
            wgt_vld_o <= 1'b0;
            psum      <= '0;
        end else begin
            act_vld_o <= act_vld_i;
            wgt_vld_o <= wgt_vld_i;
            if (clr) begin
                psum <= '0;
            end else if (act_vld_i && wgt_vld_i) begin
                psum <= psum + psum_t'(prod);
            end
        end
    end

endmodule

// File: hw/sya_pe_array.sv
/*
 * Output-stationary PE grid
 * Cells chained east for activations and south for weights,
 * full accumulator matrix exposed
 */
`include "sya_settings.svh"

module sya_pe_array
    import sya_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                acc_clr,
    input  act_vec_t            act_in,
    input  logic [`SYA_DIM-1:0] act_in_vld,
    input  wgt_vec_t            wgt_in,
    input  logic [`SYA_DIM-1:0] wgt_in_vld,
    output psum_mat_t           psum
);
    // Horizontal links [row][col], col DIM is the east edge
    act_t act_h  [`SYA_DIM][`SYA_DIM+1];
    logic act_hv [`SYA_DIM][`SYA_DIM+1];
    // Vertical links [row][col], row DIM is the south edge
    wgt_t wgt_v  [`SYA_DIM+1][`SYA_DIM];
    logic wgt_vv [`SYA_DIM+1][`SYA_DIM];

    for (genvar i = 0; i < `SYA_DIM; i++) begin : g_edge
        assign act_h[i][0]  = act_in[i];
        assign act_hv[i][0] = act_in_vld[i];
        assign wgt_v[0][i]  = wgt_in[i];
        assign wgt_vv[0][i] = wgt_in_vld[i];
    end

    for (genvar r = 0; r < `SYA_DIM; r++) begin : g_row
        for (genvar c = 0; c < `SYA_DIM; c++) begin : g_col
            sya_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .clr       (acc_clr),
                .act_i     (act_h[r][c]),
                .act_vld_i (act_hv[r][c]),
                .wgt_i     (wgt_v[r][c]),
                .wgt_vld_i (wgt_vv[r][c]),
                .act_o     (act_h[r][c+1]),
                .act_vld_o (act_hv[r][c+1]),
                .wgt_o     (wgt_v[r+1][c]),
                .wgt_vld_o (wgt_vv[r+1][c]),
                .psum      (psum[r][c])
            );
        end
    end

endmodule

// File: hw/sya_drain.sv
/*
 * Result drain
 * Accumulator row select, ReLU, shift and zero-point requantization,
 * sequential output write address
 */
`include "sya_settings.svh"

module sya_drain
    import sya_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  sya_cfg_t                    cfg_q,
    input  logic                        acc_clr,
    input  logic                        drain_row_vld,
    input  logic [$clog2(`SYA_DIM)-1:0] drain_row,
    input  psum_mat_t                   psum,
    output logic                        ofm_wr_vld,
    output ofm_wr_t                     ofm_wr
);
    psum_t [`SYA_DIM-1:0] row_sel;
    act_vec_t             rq;
    act_vec_t             row_q;
    addr_t                wr_addr;

    assign row_sel = psum[drain_row];

    // Negative clamps to 0, else low byte of the shifted value plus zp
    always_comb begin
        for (int c = 0; c < `SYA_DIM; c++) begin
            if (row_sel[c] < 0) begin
                rq[c] = '0;
            end else begin
                rq[c] = act_t'(row_sel[c] >> cfg_q.shift) + cfg_q.zp;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (drain_row_vld) begin
            row_q <= rq;
        end
    end

    // A clear with no write in flight marks the start of a run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld <= 1'b0;
            wr_addr    <= '0;
        end else begin
            ofm_wr_vld <= drain_row_vld;
            if (acc_clr && !ofm_wr_vld) begin
                wr_addr <= cfg_q.ofm_base;
            end else if (ofm_wr_vld) begin
                wr_addr <= wr_addr + addr_t'(1);
            end
        end
    end

    assign ofm_wr.addr = wr_addr;
    assign ofm_wr.data = row_q;

endmodule

// File: hw/sya_top.sv
/*
 * Systolic matrix engine top level
 * Control, read addressing, operand skew, PE grid and drain
 */
`include "sya_settings.svh"

module sya_top
    import sya_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_vld,
    input  sya_cfg_t cfg,
    output logic     cfg_rdy,
    output logic     rd_req,
    output addr_t    act_rd_addr,
    output addr_t    wgt_rd_addr,
    input  act_vec_t rd_act,
    input  wgt_vec_t rd_wgt,
    input  logic     rd_vld,
    output logic     ofm_wr_vld,
    output ofm_wr_t  ofm_wr
);
    // ============================================================
    // Internal nets
    // ============================================================
    sya_cfg_t                    cfg_q;
    sya_state_e                  state;
    cnt_t                        k;
    cnt_t                        g;
    logic                        acc_clr;
    logic                        drain_row_vld;
    logic [$clog2(`SYA_DIM)-1:0] drain_row;
    act_vec_t                    act_in;
    logic [`SYA_DIM-1:0]         act_in_vld;
    wgt_vec_t                    wgt_in;
    logic [`SYA_DIM-1:0]         wgt_in_vld;
    psum_mat_t                   psum;

    // ============================================================
    // Blocks
    // ============================================================
    sya_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_vld       (cfg_vld),
        .cfg           (cfg),
        .cfg_rdy       (cfg_rdy),
        .cfg_q         (cfg_q),
        .state         (state),
        .k             (k),
        .g             (g),
        .acc_clr       (acc_clr),
        .drain_row_vld (drain_row_vld),
        .drain_row     (drain_row)
    );

    sya_addr_gen u_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .cfg_q       (cfg_q),
        .k           (k),
        .g           (g),
        .rd_req      (rd_req),
        .act_rd_addr (act_rd_addr),
        .wgt_rd_addr (wgt_rd_addr)
    );

    sya_skew u_skew (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_act     (rd_act),
        .rd_wgt     (rd_wgt),
        .rd_vld     (rd_vld),
        .act_in     (act_in),
        .act_in_vld (act_in_vld),
        .wgt_in     (wgt_in),
        .wgt_in_vld (wgt_in_vld)
    );

    sya_pe_array u_pe_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_clr    (acc_clr),
        .act_in     (act_in),
        .act_in_vld (act_in_vld),
        .wgt_in     (wgt_in),
        .wgt_in_vld (wgt_in_vld),
        .psum       (psum)
    );

    sya_drain u_drain (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_q         (cfg_q),
        .acc_clr       (acc_clr),
        .drain_row_vld (drain_row_vld),
        .drain_row     (drain_row),
        .psum          (psum),
        .ofm_wr_vld    (ofm_wr_vld),
        .ofm_wr        (ofm_wr)
    );

endmodule

// File: bench/sya_tb_checks.svh
/*
 * Testbench compare tasks
 * Typed checks for activations, addresses and single bits,
 * error counters and the closing count line
 */

    int n_checks    = 0;
    int n_val_err   = 0;
    int n_other_err = 0;

    task automatic check_act(input string name, input act_t got, input act_t exp);
        n_checks++;
        if (got !== exp) begin
            n_val_err++;
            $display("[ERROR] t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_val_err++;
            $display("[ERROR] t=%0t %s got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_val_err++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Protocol and timing problems, no single value to compare
    task automatic report_other(input string msg);
        n_other_err++;
        $display("Failure at t=%0t: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("%0d checks, %0d value errors, %0d other errors",
                 n_checks, n_val_err, n_other_err);
    endtask

// File: bench/sya_tb.sv
/*
 * Systolic engine testbench
 * Clock and reset, global buffer model, stimulus table,
 * reference model, output monitors and watchdog
 */
`include "sya_settings.svh"

module sya_tb
    import sya_pkg::*;
();
    localparam int MEM_DEPTH = 256;
    localparam int NUM_ROWS  = 6;

    typedef struct packed {
        sya_cfg_t cfg;
        logic     force_neg;
    } test_row_t;

    typedef struct packed {
        addr_t act;
        addr_t wgt;
    } rd_pair_t;

    logic     clk;
    logic     rst_n;
    logic     cfg_vld;
    sya_cfg_t cfg;
    logic     cfg_rdy;
    logic     rd_req;
    addr_t    act_rd_addr;
    addr_t    wgt_rd_addr;
    act_vec_t rd_act = '0;
    wgt_vec_t rd_wgt = '0;
    logic     rd_vld = 1'b0;
    logic     ofm_wr_vld;
    ofm_wr_t  ofm_wr;

    // Buffer contents and one-deep read pipeline
    act_vec_t act_mem [MEM_DEPTH];
    wgt_vec_t wgt_mem [MEM_DEPTH];
    logic     rd_pend  = 1'b0;
    addr_t    act_pend = '0;
    addr_t    wgt_pend = '0;
    int       seed     = 77;

    rd_pair_t rd_exp_q [$];
    ofm_wr_t  wr_exp_q [$];

    // act_base, wgt_base, ofm_base, chn, num_grp, shift, zp, then forced-negative flag
    test_row_t tbl [NUM_ROWS] = '{
        '{'{16'h0000, 16'h0080, 16'h0100, 8'd6,  8'd1, 4'd0, 8'h00}, 1'b0},
        '{'{16'h0020, 16'h0090, 16'h0200, 8'd5,  8'd1, 4'd0, 8'h05}, 1'b1},
        '{'{16'h0030, 16'h00a0, 16'h0300, 8'd10, 8'd1, 4'd4, 8'h9c}, 1'b0},
        '{'{16'h0040, 16'h00b0, 16'h0400, 8'd7,  8'd3, 4'd2, 8'h03}, 1'b0},
        '{'{16'h0060, 16'h00c0, 16'h0500, 8'd1,  8'd4, 4'd1, 8'h00}, 1'b0},
        '{'{16'h0070, 16'h00d0, 16'h0600, 8'd16, 8'd2, 4'd3, 8'h40}, 1'b0}
    };

    `include "sya_tb_checks.svh"

    sya_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Buffer model and monitors
    // ============================================================
    always @(negedge clk) begin : buffer_model
        rd_pair_t exp_rd;
        rd_vld   <= rd_pend;
        rd_act   <= rd_pend ? act_mem[act_pend[7:0]] : '0;
        rd_wgt   <= rd_pend ? wgt_mem[wgt_pend[7:0]] : '0;
        rd_pend  <= rd_req;
        act_pend <= act_rd_addr;
        wgt_pend <= wgt_rd_addr;
        if (rd_req) begin
            if (rd_exp_q.size() == 0) begin
                report_other("read request when no read was expected");
            end else begin
                exp_rd = rd_exp_q.pop_front();
                check_addr("act_rd_addr", act_rd_addr, exp_rd.act);
                check_addr("wgt_rd_addr", wgt_rd_addr, exp_rd.wgt);
            end
        end
    end

    always @(negedge clk) begin : write_monitor
        ofm_wr_t exp_wr;
        if (ofm_wr_vld) begin
            if (wr_exp_q.size() == 0) begin
                report_other("output write when no row was expected");
            end else begin
                exp_wr = wr_exp_q.pop_front();
                check_addr("ofm_wr.addr", ofm_wr.addr, exp_wr.addr);
                for (int c = 0; c < `SYA_DIM; c++) begin
                    check_act($sformatf("ofm_wr.data[%0d]", c), ofm_wr.data[c], exp_wr.data[c]);
                end
            end
        end
    end

    // ============================================================
    // Reference model
    // ============================================================
    function automatic act_t requantize(input int sum, input logic [3:0] shift, input act_t zp);
        int shifted;
        if (sum < 0) begin
            return '0;
        end
        shifted = sum >> shift;
        return act_t'(shifted[7:0] + zp);
    endfunction

    task automatic fill_buffers();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int r = 0; r < `SYA_DIM; r++) begin
                act_mem[a][r] = act_t'($random(seed));
                wgt_mem[a][r] = wgt_t'($random(seed));
            end
        end
    endtask

    // Negative activations against positive weights, every sum below zero
    task automatic force_negative(input sya_cfg_t c);
        addr_t a;
        for (int i = 0; i < c.num_grp * c.chn; i++) begin
            a = c.act_base + addr_t'(i);
            for (int r = 0; r < `SYA_DIM; r++) begin
                act_mem[a[7:0]][r] = act_t'(-1 - ($random(seed) & 63));
            end
        end
        for (int k = 0; k < c.chn; k++) begin
            a = c.wgt_base + addr_t'(k);
            for (int col = 0; col < `SYA_DIM; col++) begin
                wgt_mem[a[7:0]][col] = wgt_t'(1 + ($random(seed) & 63));
            end
        end
    endtask

    task automatic build_expected(input sya_cfg_t c);
        rd_pair_t rp;
        ofm_wr_t  wr;
        act_t     a;
        wgt_t     b;
        int       sum;
        for (int g = 0; g < c.num_grp; g++) begin
            for (int k = 0; k < c.chn; k++) begin
                rp.act = c.act_base + addr_t'(g * c.chn + k);
                rp.wgt = c.wgt_base + addr_t'(k);
                rd_exp_q.push_back(rp);
            end
            for (int r = 0; r < `SYA_DIM; r++) begin
                for (int col = 0; col < `SYA_DIM; col++) begin
                    sum = 0;
                    for (int k = 0; k < c.chn; k++) begin
                        rp.act = c.act_base + addr_t'(g * c.chn + k);
                        rp.wgt = c.wgt_base + addr_t'(k);
                        a      = act_mem[rp.act[7:0]][r];
                        b      = wgt_mem[rp.wgt[7:0]][col];
                        sum    = sum + a * b;
                    end
                    wr.data[col] = requantize(sum, c.shift, c.zp);
                end
                wr.addr = c.ofm_base + addr_t'(g * `SYA_DIM + r);
                wr_exp_q.push_back(wr);
            end
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic run_case(input test_row_t row);
        int cyc;
        int run_len;
        run_len = row.cfg.num_grp * (row.cfg.chn + 4 * `SYA_DIM);
        if (row.force_neg) begin
            force_negative(row.cfg);
        end
        build_expected(row.cfg);
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        cfg     = row.cfg;
        cfg_vld = 1'b1;
        @(negedge clk);
        check_bit("cfg_rdy", cfg_rdy, 1'b0);
        cyc = 0;
        while (!cfg_rdy) begin
            cyc++;
            // Stray configuration pulse while busy
            cfg_vld = (cyc == 2);
            cfg     = (cyc == 2) ? ~row.cfg : '0;
            @(negedge clk);
        end
        cfg_vld = 1'b0;
        if (cyc != run_len) begin
            report_other($sformatf("run took %0d cycles instead of %0d", cyc, run_len));
        end
        @(negedge clk);
        check_bit("rd_req", rd_req, 1'b0);
        check_bit("ofm_wr_vld", ofm_wr_vld, 1'b0);
        if (rd_exp_q.size() != 0) begin
            report_other($sformatf("%0d expected reads never happened", rd_exp_q.size()));
        end
        if (wr_exp_q.size() != 0) begin
            report_other($sformatf("%0d expected rows were never written", wr_exp_q.size()));
        end
        rd_exp_q.delete();
        wr_exp_q.delete();
    endtask

    initial begin
        rst_n   = 1'b0;
        cfg_vld = 1'b0;
        cfg     = '0;
        fill_buffers();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        check_bit("rd_req", rd_req, 1'b0);
        check_bit("ofm_wr_vld", ofm_wr_vld, 1'b0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_case(tbl[i]);
        end
        print_counts();
        if (n_val_err + n_other_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Limit from the run lengths of the whole table plus margin
    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = 50;
        foreach (tbl[i]) begin
            limit += tbl[i].cfg.num_grp * (tbl[i].cfg.chn + 4 * `SYA_DIM) + 10;
        end
        repeat (limit) @(posedge clk);
        report_other($sformatf("run did not finish within %0d cycles", limit));
        print_counts();
        $display("Errors found");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
+incdir+bench
hw/sya_pkg.sv
hw/sya_ctrl.sv
hw/sya_addr_gen.sv
hw/sya_skew.sv
hw/sya_pe.sv
hw/sya_pe_array.sv
hw/sya_drain.sv
hw/sya_top.sv
bench/sya_tb.sv

// File: Makefile
# Verilator build and run for the systolic engine testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= sya_tb
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
